// ==== cpu_pkg.sv ====
package cpu_pkg;

	localparam int xlen = 32;
	localparam int reg_aw = 5;

	localparam logic [xlen-1:0] reset_pc = '0;
	// one word per instruction
	localparam logic [xlen-1:0] pc_step = 4;

	// funct3 codes of the supported subset
	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_word = 3'b010;
	localparam logic [2:0] f3_beq = 3'b000;

	// major opcodes, RV32I encodings
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011
	} opcode_e;

	typedef enum logic [1:0] {
		alu_add = 2'd0,
		alu_sub = 2'd1,
		alu_and = 2'd2,
		alu_or  = 2'd3
	} alu_op_e;

	// what the WB stage writes back
	typedef enum logic {
		wb_alu = 1'b0,
		wb_mem = 1'b1
	} wb_sel_e;

	// where an EX operand comes from
	typedef enum logic [2:0] {
		fwd_none    = 3'd0,
		fwd_mem_alu = 3'd1,
		fwd_wb_alu  = 3'd2,
		fwd_wb_mem  = 3'd3
	} fwd_e;

endpackage

// ==== stage_if.sv ====
`timescale 1ns/1ns

// destination of the instruction held in one pipeline stage
interface stage_if;

	logic                       regwr;
	cpu_pkg::wb_sel_e           wbsel;
	logic [cpu_pkg::reg_aw-1:0] rd;
	// result known so far, zero in EX
	logic [cpu_pkg::xlen-1:0]   value;

	modport producer (
		output regwr, wbsel, rd, value
	);

	modport consumer (
		input regwr, wbsel, rd, value
	);

endinterface

// ==== hazard.sv ====
`timescale 1ns/1ns

module hazard (
	input  logic [cpu_pkg::reg_aw-1:0] id_rs1,
	input  logic [cpu_pkg::reg_aw-1:0] id_rs2,
	stage_if.consumer                  ex_info,
	stage_if.consumer                  mem_info,
	stage_if.consumer                  wb_info,
	output cpu_pkg::fwd_e              rs1_fwd,
	output cpu_pkg::fwd_e              rs2_fwd,
	output logic                       stall
);

	// EX instruction writes this source
	function automatic logic ex_hit(input logic [cpu_pkg::reg_aw-1:0] s);
		return (s != '0) && ex_info.regwr && (ex_info.rd == s);
	endfunction

	// load in EX, its data is not there in time
	function automatic logic load_use(input logic [cpu_pkg::reg_aw-1:0] s);
		return ex_hit(s) && (ex_info.wbsel == cpu_pkg::wb_mem);
	endfunction

	// youngest writer wins, EX before MEM before WB
	function automatic cpu_pkg::fwd_e pick_src(input logic [cpu_pkg::reg_aw-1:0] s);
		if (s == '0) begin
			return cpu_pkg::fwd_none;
		end
		if (ex_hit(s)) begin
			if (ex_info.wbsel == cpu_pkg::wb_mem) begin
				// stall takes over, the choice is dropped with the bubble
				return cpu_pkg::fwd_none;
			end
			// result sits in MEM when this one reaches EX
			return cpu_pkg::fwd_mem_alu;
		end
		if (mem_info.regwr && (mem_info.rd == s)) begin
			if (mem_info.wbsel == cpu_pkg::wb_mem) begin
				return cpu_pkg::fwd_wb_mem;
			end
			return cpu_pkg::fwd_wb_alu;
		end
		if (wb_info.regwr && (wb_info.rd == s)) begin
			// regfile write-through covers this case
			return cpu_pkg::fwd_none;
		end
		return cpu_pkg::fwd_none;
	endfunction

	always_comb begin
		rs1_fwd = pick_src(id_rs1);
		rs2_fwd = pick_src(id_rs2);
		stall = load_use(id_rs1) || load_use(id_rs2);
	end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ns

module regfile (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [cpu_pkg::reg_aw-1:0] rs1,
	input  logic [cpu_pkg::reg_aw-1:0] rs2,
	input  logic                       wr_en,
	input  logic [cpu_pkg::reg_aw-1:0] wr_idx,
	input  logic [cpu_pkg::xlen-1:0]   wr_data,
	output logic [cpu_pkg::xlen-1:0]   rd1,
	output logic [cpu_pkg::xlen-1:0]   rd2
);

	logic [cpu_pkg::xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst && wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// x0 reads zero and a same-cycle write passes through
	function automatic logic [cpu_pkg::xlen-1:0] read_port(
		input logic [cpu_pkg::reg_aw-1:0] idx
	);
		if (idx == '0) begin
			return '0;
		end
		if (wr_en && (wr_idx == idx)) begin
			return wr_data;
		end
		return regs[idx];
	endfunction

	always_comb begin
		rd1 = read_port(rs1);
		rd2 = read_port(rs2);
	end

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ns

module decoder (
	input  logic [cpu_pkg::xlen-1:0]   instr,
	output logic [cpu_pkg::reg_aw-1:0] rs1,
	output logic [cpu_pkg::reg_aw-1:0] rs2,
	output logic [cpu_pkg::reg_aw-1:0] rd,
	output logic [cpu_pkg::xlen-1:0]   imm,
	output cpu_pkg::alu_op_e           alu_op,
	output logic                       use_imm,
	output logic                       regwr,
	output cpu_pkg::wb_sel_e           wbsel,
	output logic                       is_store,
	output logic                       is_branch
);

	cpu_pkg::opcode_e         opcode;
	logic [2:0]               funct3;
	logic [cpu_pkg::xlen-1:0] imm_i;
	logic [cpu_pkg::xlen-1:0] imm_s;
	logic [cpu_pkg::xlen-1:0] imm_b;

	assign opcode = cpu_pkg::opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

	always_comb begin
		// bubble unless a supported encoding matches
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		imm = '0;
		alu_op = cpu_pkg::alu_add;
		use_imm = 1'b0;
		regwr = 1'b0;
		wbsel = cpu_pkg::wb_alu;
		is_store = 1'b0;
		is_branch = 1'b0;
		case (opcode)
			cpu_pkg::op_reg: begin
				if (funct3 == cpu_pkg::f3_add_sub || funct3 == cpu_pkg::f3_and ||
					funct3 == cpu_pkg::f3_or) begin
					rs1 = instr[19:15];
					rs2 = instr[24:20];
					rd = instr[11:7];
					regwr = 1'b1;
					if (funct3 == cpu_pkg::f3_and) begin
						alu_op = cpu_pkg::alu_and;
					end else if (funct3 == cpu_pkg::f3_or) begin
						alu_op = cpu_pkg::alu_or;
					end else if (instr[30]) begin
						// funct7 0100000 selects sub
						alu_op = cpu_pkg::alu_sub;
					end
				end
			end
			cpu_pkg::op_imm: begin
				if (funct3 == cpu_pkg::f3_add_sub) begin
					rs1 = instr[19:15];
					rd = instr[11:7];
					imm = imm_i;
					use_imm = 1'b1;
					regwr = 1'b1;
				end
			end
			cpu_pkg::op_load: begin
				if (funct3 == cpu_pkg::f3_word) begin
					rs1 = instr[19:15];
					rd = instr[11:7];
					imm = imm_i;
					use_imm = 1'b1;
					regwr = 1'b1;
					wbsel = cpu_pkg::wb_mem;
				end
			end
			cpu_pkg::op_store: begin
				if (funct3 == cpu_pkg::f3_word) begin
					rs1 = instr[19:15];
					rs2 = instr[24:20];
					imm = imm_s;
					use_imm = 1'b1;
					is_store = 1'b1;
				end
			end
			cpu_pkg::op_branch: begin
				if (funct3 == cpu_pkg::f3_beq) begin
					rs1 = instr[19:15];
					rs2 = instr[24:20];
					imm = imm_b;
					is_branch = 1'b1;
				end
			end
			default: begin
				// unknown opcode stays a bubble
			end
		endcase
	end

endmodule

// ==== execute.sv ====
`timescale 1ns/1ns

module execute (
	input  cpu_pkg::fwd_e            rs1_fwd,
	input  cpu_pkg::fwd_e            rs2_fwd,
	input  logic [cpu_pkg::xlen-1:0] rf_rs1,
	input  logic [cpu_pkg::xlen-1:0] rf_rs2,
	input  logic [cpu_pkg::xlen-1:0] mem_alu,
	input  logic [cpu_pkg::xlen-1:0] wb_value,
	input  logic [cpu_pkg::xlen-1:0] imm,
	input  logic [cpu_pkg::xlen-1:0] pc,
	input  cpu_pkg::alu_op_e         alu_op,
	input  logic                     use_imm,
	input  logic                     is_branch,
	output logic [cpu_pkg::xlen-1:0] alu_result,
	output logic [cpu_pkg::xlen-1:0] store_data,
	output logic                     branch_taken,
	output logic [cpu_pkg::xlen-1:0] branch_target
);

	logic [cpu_pkg::xlen-1:0] op_a;
	logic [cpu_pkg::xlen-1:0] op_b;
	logic [cpu_pkg::xlen-1:0] alu_b;

	// wb_value is already muxed between alu result and load data
	function automatic logic [cpu_pkg::xlen-1:0] pick(
		input cpu_pkg::fwd_e            src,
		input logic [cpu_pkg::xlen-1:0] rf_val
	);
		case (src)
			cpu_pkg::fwd_mem_alu: return mem_alu;
			cpu_pkg::fwd_wb_alu, cpu_pkg::fwd_wb_mem: return wb_value;
			default: return rf_val;
		endcase
	endfunction

	always_comb begin
		op_a = pick(rs1_fwd, rf_rs1);
		op_b = pick(rs2_fwd, rf_rs2);
	end

	assign alu_b = use_imm ? imm : op_b;

	always_comb begin
		case (alu_op)
			cpu_pkg::alu_sub: alu_result = op_a - alu_b;
			cpu_pkg::alu_and: alu_result = op_a & alu_b;
			cpu_pkg::alu_or: alu_result = op_a | alu_b;
			default: alu_result = op_a + alu_b;
		endcase
	end

	// sw data is rs2 after forwarding
	assign store_data = op_b;

	// beq only
	assign branch_taken = is_branch && (op_a == op_b);
	assign branch_target = pc + imm;

endmodule

// ==== data_port.sv ====
`timescale 1ns/1ns

module data_port (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     req,
	input  logic                     we,
	input  logic [cpu_pkg::xlen-1:0] addr,
	input  logic [cpu_pkg::xlen-1:0] wdata,
	output logic [cpu_pkg::xlen-1:0] rdata,
	output logic                     busy,
	output logic                     dwb_cyc,
	output logic                     dwb_stb,
	output logic                     dwb_we,
	output logic [cpu_pkg::xlen-1:0] dwb_adr,
	output logic [cpu_pkg::xlen-1:0] dwb_wdata,
	input  logic [cpu_pkg::xlen-1:0] dwb_rdata,
	input  logic                     dwb_ack
);

	typedef enum logic {
		st_idle,
		st_active
	} state_e;

	state_e state;
	// high for the cycle right after an ack
	logic   gap;
	logic   ack_hit;

	// cyc rises with the request, then the state holds it
	assign dwb_cyc = (state == st_active) || (req && !gap);
	assign dwb_stb = dwb_cyc;
	assign dwb_we = we;
	// stable while the pipeline is frozen
	assign dwb_adr = addr;
	assign dwb_wdata = wdata;

	assign ack_hit = dwb_cyc && dwb_ack;
	assign busy = req && !ack_hit;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			gap <= 1'b0;
		end else begin
			gap <= ack_hit;
			if (ack_hit) begin
				state <= st_idle;
			end else if (dwb_cyc) begin
				state <= st_active;
			end
		end
	end

	// load data, read in WB
	always_ff @(posedge clk) begin
		if (ack_hit && !we) begin
			rdata <= dwb_rdata;
		end
	end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
	input  logic                     clk,
	input  logic                     rst,
	output logic [cpu_pkg::xlen-1:0] imem_addr,
	input  logic [cpu_pkg::xlen-1:0] imem_data,
	output logic                     dwb_cyc,
	output logic                     dwb_stb,
	output logic                     dwb_we,
	output logic [cpu_pkg::xlen-1:0] dwb_adr,
	output logic [cpu_pkg::xlen-1:0] dwb_wdata,
	input  logic [cpu_pkg::xlen-1:0] dwb_rdata,
	input  logic                     dwb_ack
);

	logic [cpu_pkg::xlen-1:0]   pc;
	logic [cpu_pkg::xlen-1:0]   id_instr;
	logic [cpu_pkg::xlen-1:0]   id_pc;
	logic [cpu_pkg::reg_aw-1:0] id_rs1;
	logic [cpu_pkg::reg_aw-1:0] id_rs2;
	logic [cpu_pkg::reg_aw-1:0] id_rd;
	logic [cpu_pkg::xlen-1:0]   id_imm;
	logic [cpu_pkg::xlen-1:0]   id_rf1;
	logic [cpu_pkg::xlen-1:0]   id_rf2;
	cpu_pkg::alu_op_e           id_alu_op;
	logic                       id_use_imm;
	logic                       id_regwr;
	cpu_pkg::wb_sel_e           id_wbsel;
	logic                       id_is_store;
	logic                       id_is_branch;
	cpu_pkg::fwd_e              id_rs1_fwd;
	cpu_pkg::fwd_e              id_rs2_fwd;

	// ID/EX, destination fields live in ex_info
	logic [cpu_pkg::xlen-1:0]   ex_pc;
	logic [cpu_pkg::xlen-1:0]   ex_rf1;
	logic [cpu_pkg::xlen-1:0]   ex_rf2;
	logic [cpu_pkg::xlen-1:0]   ex_imm;
	cpu_pkg::alu_op_e           ex_alu_op;
	logic                       ex_use_imm;
	logic                       ex_is_store;
	logic                       ex_is_branch;
	cpu_pkg::fwd_e              ex_rs1_fwd;
	cpu_pkg::fwd_e              ex_rs2_fwd;
	logic [cpu_pkg::xlen-1:0]   ex_alu;
	logic [cpu_pkg::xlen-1:0]   ex_store_data;
	logic [cpu_pkg::xlen-1:0]   ex_target;

	logic [cpu_pkg::xlen-1:0]   mem_wdata;
	logic                       mem_is_store;
	logic [cpu_pkg::xlen-1:0]   mem_rdata;
	logic [cpu_pkg::xlen-1:0]   wb_alu;

	logic                       stall;
	logic                       freeze;
	logic                       flush;
	logic                       id_kill;

	stage_if ex_info ();
	stage_if mem_info ();
	stage_if wb_info ();

	assign imem_addr = pc;
	assign id_kill = flush || stall;
	assign ex_info.value = '0;
	assign wb_info.value = (wb_info.wbsel == cpu_pkg::wb_mem) ? mem_rdata : wb_alu;

	decoder decoder_inst (
		.instr(id_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm),
		.alu_op(id_alu_op), .use_imm(id_use_imm), .regwr(id_regwr), .wbsel(id_wbsel),
		.is_store(id_is_store), .is_branch(id_is_branch)
	);

	regfile regfile_inst (
		.clk(clk), .rst(rst), .rs1(id_rs1), .rs2(id_rs2),
		.wr_en(wb_info.regwr), .wr_idx(wb_info.rd), .wr_data(wb_info.value),
		.rd1(id_rf1), .rd2(id_rf2)
	);

	hazard hazard_inst (
		.id_rs1(id_rs1), .id_rs2(id_rs2),
		.ex_info(ex_info), .mem_info(mem_info), .wb_info(wb_info),
		.rs1_fwd(id_rs1_fwd), .rs2_fwd(id_rs2_fwd), .stall(stall)
	);

	execute execute_inst (
		.rs1_fwd(ex_rs1_fwd), .rs2_fwd(ex_rs2_fwd), .rf_rs1(ex_rf1), .rf_rs2(ex_rf2),
		.mem_alu(mem_info.value), .wb_value(wb_info.value), .imm(ex_imm), .pc(ex_pc),
		.alu_op(ex_alu_op), .use_imm(ex_use_imm), .is_branch(ex_is_branch),
		.alu_result(ex_alu), .store_data(ex_store_data),
		.branch_taken(flush), .branch_target(ex_target)
	);

	data_port data_port_inst (
		.clk(clk), .rst(rst),
		.req(mem_is_store || (mem_info.regwr && mem_info.wbsel == cpu_pkg::wb_mem)),
		.we(mem_is_store), .addr(mem_info.value), .wdata(mem_wdata),
		.rdata(mem_rdata), .busy(freeze),
		.dwb_cyc(dwb_cyc), .dwb_stb(dwb_stb), .dwb_we(dwb_we), .dwb_adr(dwb_adr),
		.dwb_wdata(dwb_wdata), .dwb_rdata(dwb_rdata), .dwb_ack(dwb_ack)
	);

	// freeze beats flush, flush beats stall
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= cpu_pkg::reset_pc;
			// zero word decodes as a bubble
			id_instr <= '0;
		end else if (!freeze) begin
			if (flush) begin
				pc <= ex_target;
				id_instr <= '0;
			end else if (!stall) begin
				pc <= pc + cpu_pkg::pc_step;
				id_instr <= imem_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_info.regwr <= 1'b0;
			ex_is_store <= 1'b0;
			ex_is_branch <= 1'b0;
			mem_info.regwr <= 1'b0;
			mem_is_store <= 1'b0;
			wb_info.regwr <= 1'b0;
		end else if (!freeze) begin
			ex_info.regwr <= id_regwr && !id_kill;
			ex_is_store <= id_is_store && !id_kill;
			ex_is_branch <= id_is_branch && !id_kill;
			mem_info.regwr <= ex_info.regwr;
			mem_is_store <= ex_is_store;
			wb_info.regwr <= mem_info.regwr;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			if (!stall) begin
				id_pc <= pc;
			end
			ex_pc <= id_pc;
			ex_rf1 <= id_rf1;
			ex_rf2 <= id_rf2;
			ex_imm <= id_imm;
			ex_alu_op <= id_alu_op;
			ex_use_imm <= id_use_imm;
			ex_rs1_fwd <= id_rs1_fwd;
			ex_rs2_fwd <= id_rs2_fwd;
			ex_info.rd <= id_rd;
			ex_info.wbsel <= id_wbsel;
			mem_info.rd <= ex_info.rd;
			mem_info.wbsel <= ex_info.wbsel;
			mem_info.value <= ex_alu;
			mem_wdata <= ex_store_data;
			wb_info.rd <= mem_info.rd;
			wb_info.wbsel <= mem_info.wbsel;
			wb_alu <= mem_info.value;
		end
	end

endmodule

// ==== tb_cpu_checker.sv ====
`timescale 1ns/1ns

module tb_cpu_checker (
	input logic                     clk,
	input logic                     rst,
	input logic [cpu_pkg::xlen-1:0] imem_addr,
	input logic                     dwb_cyc,
	input logic                     dwb_stb,
	input logic                     dwb_we,
	input logic [cpu_pkg::xlen-1:0] dwb_adr,
	input logic [cpu_pkg::xlen-1:0] dwb_wdata,
	input logic                     dwb_ack,
	input logic                     mem_is_store,
	input logic                     mem_regwr,
	input cpu_pkg::wb_sel_e         mem_wbsel,
	input logic                     flush
);

	// failed assertions, read by the testbench summary
	int unsigned fails = 0;
	// load or store sitting in MEM
	logic        mem_op;

	assign mem_op = mem_is_store || (mem_regwr && (mem_wbsel == cpu_pkg::wb_mem));

	reset_bus_idle: assert property (@(posedge clk) rst |=> !dwb_cyc && !dwb_stb)
		else begin
			fails++;
			$error("bus cycle active right after reset");
		end

	start_pc: assert property (@(posedge clk) $fell(rst) |-> imem_addr == cpu_pkg::reset_pc)
		else begin
			fails++;
			$error("first fetch after reset is not at the reset address");
		end

	bus_needs_op: assert property (@(posedge clk) disable iff (rst) !mem_op |-> !dwb_cyc)
		else begin
			fails++;
			$error("bus cycle without a load or store in MEM");
		end

	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) dwb_stb |-> dwb_cyc)
		else begin
			fails++;
			$error("stb high while cyc is low");
		end

	// request fields frozen until the slave answers
	hold_request: assert property (@(posedge clk) disable iff (rst)
		dwb_stb && !dwb_ack |=> dwb_stb && $stable(dwb_adr) && $stable(dwb_we) &&
			(!dwb_we || $stable(dwb_wdata)))
		else begin
			fails++;
			$error("bus request dropped or changed before ack");
		end

	gap_after_ack: assert property (@(posedge clk) disable iff (rst)
		dwb_stb && dwb_ack |=> !dwb_cyc)
		else begin
			fails++;
			$error("cyc still high in the cycle after ack");
		end

	store_known: assert property (@(posedge clk) disable iff (rst)
		dwb_stb && dwb_we |-> !$isunknown(dwb_wdata))
		else begin
			fails++;
			$error("store data has unknown bits");
		end

	// pc holds, steps one word, or takes a branch target
	fetch_step: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> (imem_addr[1:0] == 2'b00) && ($stable(imem_addr) ||
			(imem_addr == $past(imem_addr) + cpu_pkg::pc_step) || $past(flush)))
		else begin
			fails++;
			$error("fetch address left the sequential path without a branch");
		end

endmodule

bind cpu_top tb_cpu_checker checker_inst (
	.clk(clk),
	.rst(rst),
	.imem_addr(imem_addr),
	.dwb_cyc(dwb_cyc),
	.dwb_stb(dwb_stb),
	.dwb_we(dwb_we),
	.dwb_adr(dwb_adr),
	.dwb_wdata(dwb_wdata),
	.dwb_ack(dwb_ack),
	.mem_is_store(mem_is_store),
	.mem_regwr(mem_info.regwr),
	.mem_wbsel(mem_info.wbsel),
	.flush(flush)
);

// ==== tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

	localparam int clk_period = 40;
	localparam int reset_cycles = 10;
	localparam int prog_words = 24;
	// load with three wait cycles, the bus gap and a load-use stall
	localparam int worst_cpi = 8;
	localparam int margin_cycles = 60;
	localparam int timeout_ns =
		(reset_cycles + prog_words * worst_cpi + margin_cycles) * clk_period;
	localparam int n_stores = 7;
	// beq x0, x0, 0 is the last program word
	localparam logic [31:0] halt_addr = (prog_words - 1) * 4;
	localparam int halt_hold = 8;

	logic        clk;
	logic        rst;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic        dwb_cyc;
	logic        dwb_stb;
	logic        dwb_we;
	logic [31:0] dwb_adr;
	logic [31:0] dwb_wdata;
	logic [31:0] dwb_rdata;
	logic        dwb_ack;

	logic [31:0] rom [prog_words];
	logic [31:0] dmem [64];
	logic [31:0] exp_adr [n_stores];
	logic [31:0] exp_data [n_stores];

	integer      seed;
	int          errors;
	int          stores_seen;
	int          wait_left;
	int          halt_cycles;
	logic        in_transfer;

	cpu_top cpu_top_inst (
		.clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
		.dwb_cyc(dwb_cyc), .dwb_stb(dwb_stb), .dwb_we(dwb_we), .dwb_adr(dwb_adr),
		.dwb_wdata(dwb_wdata), .dwb_rdata(dwb_rdata), .dwb_ack(dwb_ack)
	);

	always #(clk_period / 2) clk = ~clk;

	// words past the program read as zero, a bubble
	assign imem_data = ((imem_addr >> 2) < prog_words) ? rom[imem_addr[6:2]] : '0;

	// distinct word per address, every index bit shows up
	function automatic logic [31:0] fill_word(input int idx);
		logic [7:0] a;
		a = idx[7:0];
		return {8'hd0, a, ~a, a ^ 8'h5a};
	endfunction

	// program run at ISA level, registers by number
	task automatic build_expected();
		logic [31:0] r [12];
		r[1] = 32'h5a3;
		r[2] = r[1] + 32'h0f0;
		r[3] = r[1] + r[2];
		r[4] = r[3] - r[1];
		r[5] = r[4] & r[3];
		r[6] = r[5] | r[1];
		r[7] = fill_word(16);
		r[8] = r[7] + r[1];
		r[9] = fill_word(17);
		r[10] = r[8] - r[7];
		r[11] = r[10] | r[9];
		exp_adr[0] = 32'h00;
		exp_data[0] = r[6];
		exp_adr[1] = 32'h04;
		exp_data[1] = r[8];
		exp_adr[2] = 32'h08;
		exp_data[2] = r[9];
		// x1 != x2, so the store after the first beq happens
		exp_adr[3] = 32'h0c;
		exp_data[3] = r[3];
		// x4 == x2, stores to 0x10 and 0x14 are skipped, x0 stays zero
		exp_adr[4] = 32'h18;
		exp_data[4] = 32'h0;
		exp_adr[5] = 32'h1c;
		exp_data[5] = r[10];
		exp_adr[6] = 32'h20;
		exp_data[6] = r[11];
	endtask

	// compare one bus write with the next table entry
	task automatic check_store();
		if (stores_seen >= n_stores) begin
			errors++;
			$display("store to address %h after the last expected store", dwb_adr);
		end else begin
			assert (dwb_adr === exp_adr[stores_seen]) else begin
				errors++;
				$display("Fail dwb_adr expected %h actual %h", exp_adr[stores_seen], dwb_adr);
			end
			assert (dwb_wdata === exp_data[stores_seen]) else begin
				errors++;
				$display("Fail dwb_wdata expected %h actual %h",
					exp_data[stores_seen], dwb_wdata);
			end
		end
		stores_seen++;
	endtask

	task automatic respond();
		logic [5:0] idx;
		idx = dwb_adr[7:2];
		if (dwb_we) begin
			check_store();
			dmem[idx] = dwb_wdata;
		end else begin
			dwb_rdata = dmem[idx];
		end
		dwb_ack = 1'b1;
	endtask

	// wishbone slave, ack after 0 to 3 extra cycles
	always @(negedge clk) begin
		if (rst) begin
			dwb_ack = 1'b0;
			in_transfer = 1'b0;
		end else if (dwb_ack) begin
			dwb_ack = 1'b0;
			in_transfer = 1'b0;
		end else if (dwb_stb) begin
			if (!in_transfer) begin
				in_transfer = 1'b1;
				wait_left = $random(seed) & 3;
			end
			if (wait_left == 0) begin
				respond();
			end else begin
				wait_left--;
			end
		end
	end

	// cycles spent fetching inside the final loop
	always @(negedge clk) begin
		if (!rst && (imem_addr >= halt_addr) && (imem_addr <= halt_addr + 8)) begin
			halt_cycles++;
		end else begin
			halt_cycles = 0;
		end
	end

	initial begin
		#(timeout_ns);
		$display("timeout, the program did not reach its final loop in %0d ns", timeout_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		seed = 32'hfa7;
		errors = 0;
		stores_seen = 0;
		wait_left = 0;
		halt_cycles = 0;
		in_transfer = 1'b0;
		clk = 1'b0;
		rst = 1'b1;
		dwb_rdata = '0;
		dwb_ack = 1'b0;
		$readmemh("program.hex", rom);
		for (int i = 0; i < 64; i++) begin
			dmem[i] = fill_word(i);
		end
		build_expected();
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		while ((stores_seen < n_stores) || (halt_cycles < halt_hold)) begin
			@(posedge clk);
		end
		$display("summary: %0d store errors, %0d assertion failures",
			errors, cpu_top_inst.checker_inst.fails);
		if ((errors == 0) && (cpu_top_inst.checker_inst.fails == 0)) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== program.hex ====
// one 32-bit instruction word per line in hex, the first line at address 0
// the text after each word is its assembly
5a300093 // addi x1, x0, 0x5a3
0f008113 // addi x2, x1, 0x0f0
002081b3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
003272b3 // and  x5, x4, x3
0012e333 // or   x6, x5, x1
00602023 // sw   x6, 0(x0)
04002383 // lw   x7, 0x40(x0)
00138433 // add  x8, x7, x1
00802223 // sw   x8, 4(x0)
04402483 // lw   x9, 0x44(x0)
00902423 // sw   x9, 8(x0)
00208663 // beq  x1, x2, +12 (not taken)
00302623 // sw   x3, 12(x0)
00220663 // beq  x4, x2, +12 (taken)
00102823 // sw   x1, 16(x0) (skipped)
00202a23 // sw   x2, 20(x0) (skipped)
05500013 // addi x0, x0, 0x55
00002c23 // sw   x0, 24(x0)
40740533 // sub  x10, x8, x7
00a02e23 // sw   x10, 28(x0)
009565b3 // or   x11, x10, x9
02b02023 // sw   x11, 32(x0)
00000063 // beq  x0, x0, 0

// ==== sources.f ====
cpu_pkg.sv
stage_if.sv
hazard.sv
regfile.sv
decoder.sv
execute.sv
data_port.sv
cpu_top.sv
tb_cpu_checker.sv
tb_cpu.sv
